//--- rtl/mbox_pkg.sv
`default_nettype none

package mbox_pkg;

  // one data word on the bus, in the queue storage and on both streams
  typedef logic [31:0] word_t;

  // register index, taken from wishbone address bits 3 and 2
  typedef logic [1:0] reg_idx_t;

  // fill level of one queue
  // eight bits, so a queue holds at most 255 words
  typedef logic [7:0] level_t;

  // register map
  // index 3 reads as zero and ignores writes
  localparam reg_idx_t REG_DATA   = 2'd0;
  localparam reg_idx_t REG_STATUS = 2'd1;
  localparam reg_idx_t REG_CTRL   = 2'd2;

  // status word flag positions
  localparam int unsigned STAT_TX_FULL  = 0;
  localparam int unsigned STAT_TX_EMPTY = 1;
  localparam int unsigned STAT_RX_FULL  = 2;
  localparam int unsigned STAT_RX_EMPTY = 3;
  localparam int unsigned STAT_OVERFLOW = 4;
  localparam int unsigned STAT_UNDERFLW = 5;

  // lowest bit of each level field in the status word
  localparam int unsigned STAT_TX_LVL = 8;
  localparam int unsigned STAT_RX_LVL = 16;

  // control bits act once per write, nothing is stored
  localparam int unsigned CTRL_FLUSH_TX = 0;
  localparam int unsigned CTRL_FLUSH_RX = 1;
  localparam int unsigned CTRL_CLR_ERR  = 2;

  // wishbone slave states
  typedef enum logic {
    WB_IDLE,
    WB_ACK
  } wb_state_e;

endpackage

`default_nettype wire

//--- rtl/fifo_if.sv
`timescale 1ns/100ps
`default_nettype none

interface fifo_if;
  import mbox_pkg::*;

  // written by the producer
  logic   push;
  word_t  wdata;
  // written by the consumer
  logic   pop;
  // written by the register slave for either queue
  logic   flush;
  // head word and status, written by the queue
  word_t  rdata;
  logic   full;
  logic   empty;
  level_t level;

  // flush sits in both user modports
  // the slave produces into one queue and consumes from the other
  modport producer (
    output push,
    output wdata,
    output flush,
    input  full,
    input  empty,
    input  level
  );

  modport consumer (
    output pop,
    output flush,
    input  rdata,
    input  full,
    input  empty,
    input  level
  );

  modport queue (
    input  push,
    input  wdata,
    input  pop,
    input  flush,
    output rdata,
    output full,
    output empty,
    output level
  );

endinterface

`default_nettype wire

//--- rtl/dp_ram.sv
`timescale 1ns/100ps
`default_nettype none

module dp_ram #(
  parameter int unsigned DEPTH = 8
) (
  input  logic                                        clk_i,
  input  logic                                        we_i,
  input  logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] waddr_i,
  input  logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] raddr_i,
  input  mbox_pkg::word_t                             wdata_i,
  output mbox_pkg::word_t                             rdata_o
);
  import mbox_pkg::*;

  // storage array that maps onto distributed ram on an fpga
  word_t mem_q [DEPTH];

  // write port
  // one word per rising edge
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // read port is combinational
  // the controller sees the head word in the same cycle as its read pointer
  assign rdata_o = mem_q[raddr_i];

endmodule

`default_nettype wire

//--- rtl/fifo_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module fifo_ctrl #(
  parameter int unsigned DEPTH        = 8,
  parameter bit          FALL_THROUGH = 1'b0
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  fifo_if.queue  q
);
  import mbox_pkg::*;

  // pointer width, at least one bit
  localparam int unsigned AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  typedef logic [AW-1:0] ptr_t;

  // the level field is eight bits wide
  if (DEPTH < 1 || DEPTH > 255) begin : gen_depth_check
    $error("fifo_ctrl DEPTH %0d outside 1 to 255", DEPTH);
  end

  // read and write pointers plus fill count
  ptr_t   rd_ptr_q;
  ptr_t   rd_ptr_n;
  ptr_t   wr_ptr_q;
  ptr_t   wr_ptr_n;
  level_t cnt_q;
  level_t cnt_n;

  // accepted handshakes
  logic   push_ok;
  logic   pop_ok;
  // fall-through path active
  logic   bypass;
  // ram side
  logic   ram_we;
  word_t  ram_rdata;

  // flags come straight from the count
  assign q.full  = (cnt_q == level_t'(DEPTH));
  // with fall-through, a push into an empty queue shows at once
  assign bypass  = FALL_THROUGH && (cnt_q == '0) && q.push;
  assign q.empty = (cnt_q == '0) && !bypass;
  assign q.level = cnt_q;

  // head word, the incoming word while bypassing
  assign q.rdata = bypass ? q.wdata : ram_rdata;

  // a push needs room, a pop needs a word
  assign push_ok = q.push && !q.full;
  assign pop_ok  = q.pop && !q.empty;

  always_comb begin
    rd_ptr_n = rd_ptr_q;
    wr_ptr_n = wr_ptr_q;
    cnt_n    = cnt_q;
    ram_we   = 1'b0;

    // store the word and advance the write pointer
    if (push_ok) begin
      ram_we   = 1'b1;
      wr_ptr_n = (wr_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      cnt_n    = cnt_q + 1'b1;
    end

    // advance the read pointer
    if (pop_ok) begin
      rd_ptr_n = (rd_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      cnt_n    = cnt_q - 1'b1;
    end

    // push and pop together keep the level
    if (push_ok && pop_ok) begin
      cnt_n = cnt_q;
    end

    // word passes straight through an empty queue
    // nothing written, pointers stay put
    if (bypass && q.pop) begin
      ram_we   = 1'b0;
      rd_ptr_n = rd_ptr_q;
      wr_ptr_n = wr_ptr_q;
      cnt_n    = cnt_q;
    end

    // flush beats push and pop
    if (q.flush) begin
      ram_we = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (q.flush) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      rd_ptr_q <= rd_ptr_n;
      wr_ptr_q <= wr_ptr_n;
      cnt_q    <= cnt_n;
    end
  end

  // storage with asynchronous read
  dp_ram #(
    .DEPTH (DEPTH)
  ) u_ram (
    .clk_i   (clk_i),
    .we_i    (ram_we),
    .waddr_i (wr_ptr_q),
    .raddr_i (rd_ptr_q),
    .wdata_i (q.wdata),
    .rdata_o (ram_rdata)
  );

  // a full queue leaves full only through a pop or a flush
  a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    q.full && !q.pop && !q.flush |=> q.full)
    else $error("fifo_ctrl push accepted while full");

  // an empty queue stays empty without a push
  a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cnt_q == '0) && !q.push |=> (cnt_q == '0))
    else $error("fifo_ctrl pop accepted while empty");

  a_level_max : assert property (@(posedge clk_i) disable iff (!rst_ni)
    q.level <= level_t'(DEPTH))
    else $error("fifo_ctrl level %0h above depth %0d", q.level, DEPTH);

endmodule

`default_nettype wire

//--- rtl/wb_mbox_regs.sv
`timescale 1ns/100ps
`default_nettype none

module wb_mbox_regs (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               cyc_i,
  input  logic               stb_i,
  input  logic               we_i,
  input  mbox_pkg::reg_idx_t adr_i,
  input  mbox_pkg::word_t    dat_i,
  output mbox_pkg::word_t    dat_o,
  output logic               ack_o,
  fifo_if.producer           tx,
  fifo_if.consumer           rx
);
  import mbox_pkg::*;

  wb_state_e state_q;
  wb_state_e state_n;

  // decoded accesses
  logic  access;
  logic  wr_data;
  logic  rd_data;
  logic  wr_ctrl;
  logic  clr_err;

  // transmit push, one cycle behind the access
  logic  push_q;
  word_t wdata_q;

  // sticky error bits
  logic  ovf_q;
  logic  unf_q;
  logic  ovf_set;
  logic  unf_set;

  // read path
  word_t status;
  word_t rd_word;

  always_comb begin
    state_n = state_q;
    case (state_q)
      WB_IDLE: if (cyc_i && stb_i) state_n = WB_ACK;
      WB_ACK:  state_n = WB_IDLE;
      default: state_n = WB_IDLE;
    endcase
  end

  // access happens in the idle cycle, ack follows for one cycle
  assign access = cyc_i && stb_i && (state_q == WB_IDLE);
  assign ack_o  = (state_q == WB_ACK);

  assign wr_data = access && we_i && (adr_i == REG_DATA);
  assign rd_data = access && !we_i && (adr_i == REG_DATA);
  assign wr_ctrl = access && we_i && (adr_i == REG_CTRL);

  // control bits act in the access cycle
  assign tx.flush = wr_ctrl && dat_i[CTRL_FLUSH_TX];
  assign rx.flush = wr_ctrl && dat_i[CTRL_FLUSH_RX];
  assign clr_err  = wr_ctrl && dat_i[CTRL_CLR_ERR];

  // tx push lands during the ack cycle
  // a full queue drops the word and flags overflow
  assign tx.push  = push_q && !tx.full;
  assign tx.wdata = wdata_q;
  assign ovf_set  = push_q && tx.full;

  // rx pop shares the edge that loads dat_o
  assign rx.pop  = rd_data && !rx.empty;
  assign unf_set = rd_data && rx.empty;

  always_comb begin
    status                = '0;
    status[STAT_TX_FULL]  = tx.full;
    status[STAT_TX_EMPTY] = tx.empty;
    status[STAT_RX_FULL]  = rx.full;
    status[STAT_RX_EMPTY] = rx.empty;
    status[STAT_OVERFLOW] = ovf_q;
    status[STAT_UNDERFLW] = unf_q;
    status[STAT_TX_LVL +: $bits(level_t)] = tx.level;
    status[STAT_RX_LVL +: $bits(level_t)] = rx.level;
  end

  // read mux
  // ctrl and the spare index read as zero
  always_comb begin
    case (adr_i)
      REG_DATA:   rd_word = rx.empty ? '0 : rx.rdata;
      REG_STATUS: rd_word = status;
      default:    rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= WB_IDLE;
      push_q  <= 1'b0;
      ovf_q   <= 1'b0;
      unf_q   <= 1'b0;
    end else begin
      state_q <= state_n;
      push_q  <= wr_data;
      // set by an error, cleared by the ctrl write
      ovf_q   <= (ovf_q || ovf_set) && !clr_err;
      unf_q   <= (unf_q || unf_set) && !clr_err;
    end
  end

  // data registers
  always_ff @(posedge clk_i) begin
    if (wr_data) begin
      wdata_q <= dat_i;
    end
    if (access && !we_i) begin
      dat_o <= rd_word;
    end
  end

  // master drops stb on ack, so back to back acks mean a broken handshake
  a_ack_single : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_o |=> !ack_o)
    else $error("wb_mbox_regs ack high for two cycles");

endmodule

`default_nettype wire

//--- rtl/wb_mbox.sv
`timescale 1ns/100ps
`default_nettype none

module wb_mbox #(
  parameter int unsigned DEPTH        = 8,
  parameter bit          FALL_THROUGH = 1'b0
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  // wishbone classic slave
  input  logic            wb_cyc_i,
  input  logic            wb_stb_i,
  input  logic            wb_we_i,
  input  logic [3:0]      wb_adr_i,
  input  mbox_pkg::word_t wb_dat_i,
  output mbox_pkg::word_t wb_dat_o,
  output logic            wb_ack_o,
  // transmit stream
  output logic            tx_valid_o,
  output mbox_pkg::word_t tx_data_o,
  input  logic            tx_ready_i,
  // receive stream
  input  logic            rx_valid_i,
  input  mbox_pkg::word_t rx_data_i,
  output logic            rx_ready_o
);
  import mbox_pkg::*;

  // bus to stream queue and stream to bus queue
  fifo_if tx_q ();
  fifo_if rx_q ();

  // word address
  // byte lane bits 1 and 0 are not decoded
  reg_idx_t reg_idx;

  assign reg_idx = wb_adr_i[3:2];

  // tx stream drains the head of tx_q
  assign tx_valid_o = !tx_q.empty;
  assign tx_data_o  = tx_q.rdata;
  assign tx_q.pop   = tx_valid_o && tx_ready_i;

  // rx stream fills rx_q while there is room
  assign rx_ready_o  = !rx_q.full;
  assign rx_q.push   = rx_valid_i && rx_ready_o;
  assign rx_q.wdata  = rx_data_i;

  wb_mbox_regs u_regs (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .cyc_i  (wb_cyc_i),
    .stb_i  (wb_stb_i),
    .we_i   (wb_we_i),
    .adr_i  (reg_idx),
    .dat_i  (wb_dat_i),
    .dat_o  (wb_dat_o),
    .ack_o  (wb_ack_o),
    .tx     (tx_q.producer),
    .rx     (rx_q.consumer)
  );

  fifo_ctrl #(
    .DEPTH        (DEPTH),
    .FALL_THROUGH (FALL_THROUGH)
  ) u_tx_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .q      (tx_q.queue)
  );

  fifo_ctrl #(
    .DEPTH        (DEPTH),
    .FALL_THROUGH (FALL_THROUGH)
  ) u_rx_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .q      (rx_q.queue)
  );

endmodule

`default_nettype wire

//--- dv/tb_wb_mbox.sv
`timescale 1ns/100ps
`default_nettype none

module tb_wb_mbox;
  import mbox_pkg::*;

  localparam int DEPTH = 8;
  // register word indices, bus address is index times four
  localparam logic [1:0] IDX_DATA   = 2'd0;
  localparam logic [1:0] IDX_STATUS = 2'd1;
  localparam logic [1:0] IDX_CTRL   = 2'd2;
  // control bits
  localparam int FLUSH_TX = 0;
  localparam int FLUSH_RX = 1;
  localparam int CLR_ERR  = 2;
  // wait limits, in clock cycles
  localparam int ACK_LIMIT    = 16;
  localparam int STREAM_LIMIT = 200;
  localparam int DRAIN_LIMIT  = 500;
  localparam int RUN_LIMIT_NS = 2_000_000;
  localparam int unsigned SEED = 32'h64e1_9de7;
  // tx_ready_i modes
  localparam logic [1:0] READY_LOW  = 2'd0;
  localparam logic [1:0] READY_HIGH = 2'd1;
  localparam logic [1:0] READY_RAND = 2'd2;

  logic       clk_i = 1'b0;
  logic       rst_ni;
  logic       wb_cyc_i;
  logic       wb_stb_i;
  logic       wb_we_i;
  logic [3:0] wb_adr_i;
  word_t      wb_dat_i;
  word_t      wb_dat_o;
  logic       wb_ack_o;
  logic       tx_valid_o;
  word_t      tx_data_o;
  logic       tx_ready_i;
  logic       rx_valid_i;
  word_t      rx_data_i;
  logic       rx_ready_o;

  // reference queues and sticky flags
  word_t      tx_ref[$];
  word_t      rx_ref[$];
  logic       ovf_exp;
  logic       unf_exp;
  int         tx_seen = 0;
  int         rx_seen = 0;
  int         mismatch_cnt = 0;
  int         fail_cnt = 0;
  logic [1:0] ready_mode;
  word_t      rd_got;
  word_t      rd_exp;

  wb_mbox #(
    .DEPTH        (DEPTH),
    .FALL_THROUGH (1'b0)
  ) dut0 (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .tx_valid_o (tx_valid_o),
    .tx_data_o  (tx_data_o),
    .tx_ready_i (tx_ready_i),
    .rx_valid_i (rx_valid_i),
    .rx_data_i  (rx_data_i),
    .rx_ready_o (rx_ready_o)
  );

  // 100 ns period
  always #50 clk_i = ~clk_i;

  // expected status word from queue sizes and sticky flags
  function automatic word_t status_ref(int tx_n, int rx_n, logic ovf, logic unf);
    word_t s;
    s        = '0;
    s[0]     = (tx_n == DEPTH);
    s[1]     = (tx_n == 0);
    s[2]     = (rx_n == DEPTH);
    s[3]     = (rx_n == 0);
    s[4]     = ovf;
    s[5]     = unf;
    s[15:8]  = 8'(tx_n);
    s[23:16] = 8'(rx_n);
    return s;
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      mismatch_cnt++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic report_and_finish();
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt + fail_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  // sink ready, mode picked at the edge, driven 10 ns later
  initial begin
    logic [1:0] mode;
    tx_ready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      mode = ready_mode;
      #10;
      case (mode)
        READY_LOW:  tx_ready_i = 1'b0;
        READY_HIGH: tx_ready_i = 1'b1;
        default:    tx_ready_i = (($urandom & 32'h1) != 0);
      endcase
    end
  end

  // stream compare at mid cycle
  // a handshake seen here completes at the next rising edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      check_word("tx_valid_o", word_t'(tx_valid_o), word_t'(tx_ref.size() != 0));
      check_word("rx_ready_o", word_t'(rx_ready_o), word_t'(rx_ref.size() != DEPTH));
      if (tx_valid_o && tx_ready_i && tx_ref.size() != 0) begin
        check_word("tx_data_o", tx_data_o, tx_ref.pop_front());
        tx_seen++;
      end
      if (rx_valid_i && rx_ready_o) begin
        rx_ref.push_back(rx_data_i);
        rx_seen++;
      end
    end
  end

  task automatic wb_write(input logic [1:0] idx, input word_t data);
    int   wait_n;
    logic room;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b1;
    wb_adr_i = {idx, 2'b00};
    wb_dat_i = data;
    wait_n   = 0;
    do begin
      @(posedge clk_i);
      #10;
      wait_n++;
    end while (!wb_ack_o && wait_n < ACK_LIMIT);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    assert (wb_ack_o) else begin
      fail_cnt++;
      $display("no ack for write to register %0d", idx);
    end
    // tx level in the ack cycle decides whether the push lands
    room = (tx_ref.size() < DEPTH);
    // control acts at the access edge
    if (idx == IDX_CTRL) begin
      if (data[FLUSH_TX]) begin
        tx_ref.delete();
      end
      if (data[FLUSH_RX]) begin
        rx_ref.delete();
      end
      if (data[CLR_ERR]) begin
        ovf_exp = 1'b0;
        unf_exp = 1'b0;
      end
    end
    @(posedge clk_i);
    #10;
    // word enters tx at the edge closing the ack cycle
    if (idx == IDX_DATA) begin
      if (room) begin
        tx_ref.push_back(data);
      end else begin
        ovf_exp = 1'b1;
      end
    end
  endtask

  task automatic wb_read(input logic [1:0] idx, output word_t got, output word_t exp);
    int   wait_n;
    logic rx_had;
    // expectation taken in the access cycle
    rx_had = (rx_ref.size() != 0);
    exp    = '0;
    if (idx == IDX_STATUS) begin
      exp = status_ref(tx_ref.size(), rx_ref.size(), ovf_exp, unf_exp);
    end else if (idx == IDX_DATA && rx_had) begin
      exp = rx_ref[0];
    end
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b0;
    wb_adr_i = {idx, 2'b00};
    wait_n   = 0;
    do begin
      @(posedge clk_i);
      #10;
      wait_n++;
    end while (!wb_ack_o && wait_n < ACK_LIMIT);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    assert (wb_ack_o) else begin
      fail_cnt++;
      $display("no ack for read of register %0d", idx);
    end
    got = wb_dat_o;
    // head word left rx at the access edge
    if (idx == IDX_DATA) begin
      if (rx_had) begin
        void'(rx_ref.pop_front());
      end else begin
        unf_exp = 1'b1;
      end
    end
    @(posedge clk_i);
    #10;
  endtask

  task automatic check_status();
    word_t got;
    word_t exp;
    wb_read(IDX_STATUS, got, exp);
    check_word("wb_dat_o status", got, exp);
  endtask

  // stream source with random idle gaps, holds each word until taken
  task automatic send_rx_words(input int n);
    int unsigned gap;
    int          wait_n;
    logic        taken;
    for (int i = 0; i < n; i++) begin
      gap = $urandom % 3;
      repeat (gap) begin
        @(posedge clk_i);
        #10;
      end
      rx_valid_i = 1'b1;
      rx_data_i  = $urandom;
      taken      = 1'b0;
      wait_n     = 0;
      while (!taken && wait_n < STREAM_LIMIT) begin
        @(negedge clk_i);
        taken = rx_ready_o;
        @(posedge clk_i);
        #10;
        wait_n++;
      end
      rx_valid_i = 1'b0;
      assert (taken) else begin
        fail_cnt++;
        $display("rx word %0d was not accepted in time", i);
      end
    end
  endtask

  task automatic wait_tx_drained();
    int wait_n;
    wait_n = 0;
    while (tx_ref.size() != 0 && wait_n < DRAIN_LIMIT) begin
      @(posedge clk_i);
      #10;
      wait_n++;
    end
    assert (tx_ref.size() == 0) else begin
      fail_cnt++;
      $display("tx queue did not drain in time");
    end
  endtask

  task automatic wait_rx_level(input int min_n);
    int wait_n;
    wait_n = 0;
    while (rx_ref.size() < min_n && wait_n < DRAIN_LIMIT) begin
      @(posedge clk_i);
      #10;
      wait_n++;
    end
    assert (rx_ref.size() >= min_n) else begin
      fail_cnt++;
      $display("rx queue did not reach %0d words in time", min_n);
    end
  endtask

  initial begin
    void'($urandom(SEED));
    rst_ni     = 1'b0;
    wb_cyc_i   = 1'b0;
    wb_stb_i   = 1'b0;
    wb_we_i    = 1'b0;
    wb_adr_i   = '0;
    wb_dat_i   = '0;
    rx_valid_i = 1'b0;
    rx_data_i  = '0;
    ready_mode = READY_LOW;
    ovf_exp    = 1'b0;
    unf_exp    = 1'b0;
    repeat (8) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #10;

    // state right after reset
    wb_read(IDX_STATUS, rd_got, rd_exp);
    check_word("wb_dat_o status", rd_got, status_ref(0, 0, 1'b0, 1'b0));
    check_word("tx_valid_o", word_t'(tx_valid_o), 32'h0);
    check_word("rx_ready_o", word_t'(rx_ready_o), 32'h1);

    // bus to stream under a random sink
    ready_mode = READY_RAND;
    for (int i = 0; i < 20; i++) begin
      wb_write(IDX_DATA, $urandom);
      check_status();
    end
    wait_tx_drained();
    check_word("tx words delivered", word_t'(tx_seen), 32'd20);

    // stream to bus, source runs into a full queue before reads start
    ready_mode = READY_LOW;
    fork
      send_rx_words(12);
      begin
        wait_rx_level(DEPTH);
        for (int i = 0; i < 12; i++) begin
          wait_rx_level(1);
          wb_read(IDX_DATA, rd_got, rd_exp);
          check_word("wb_dat_o data", rd_got, rd_exp);
        end
      end
    join
    check_word("rx words accepted", word_t'(rx_seen), 32'd12);

    // overflow on a blocked sink, underflow on an empty rx queue
    for (int i = 0; i < 9; i++) begin
      wb_write(IDX_DATA, 32'hc0de_0000 | word_t'(i));
    end
    check_status();
    wb_read(IDX_DATA, rd_got, rd_exp);
    check_word("wb_dat_o data", rd_got, 32'h0);
    check_status();
    wb_write(IDX_CTRL, 32'h1 << CLR_ERR);
    check_status();
    // eight words come out, the ninth was dropped
    ready_mode = READY_HIGH;
    wait_tx_drained();
    check_word("tx words delivered", word_t'(tx_seen), 32'd28);

    // flush both queues while they hold data
    ready_mode = READY_LOW;
    for (int i = 0; i < 3; i++) begin
      wb_write(IDX_DATA, 32'hf1f0_0000 | word_t'(i));
    end
    send_rx_words(3);
    check_status();
    wb_write(IDX_CTRL, 32'h1 << FLUSH_TX);
    check_status();
    check_word("tx_valid_o", word_t'(tx_valid_o), 32'h0);
    wb_write(IDX_CTRL, 32'h1 << FLUSH_RX);
    wb_read(IDX_STATUS, rd_got, rd_exp);
    check_word("wb_dat_o status", rd_got, status_ref(0, 0, 1'b0, 1'b0));

    report_and_finish();
  end

  // overall limit on the run
  initial begin
    #(RUN_LIMIT_NS);
    fail_cnt++;
    $display("run did not finish within %0d ns", RUN_LIMIT_NS);
    report_and_finish();
  end

endmodule

`default_nettype wire

//--- wb_mbox.f
rtl/mbox_pkg.sv
rtl/fifo_if.sv
rtl/dp_ram.sv
rtl/fifo_ctrl.sv
rtl/wb_mbox_regs.sv
rtl/wb_mbox.sv
dv/tb_wb_mbox.sv

//--- Makefile
# Verilator build and run for the wishbone mailbox
# every variable can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_wb_mbox
FILELIST  ?= wb_mbox.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= sim passed

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

# build the simulation binary from the file list
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# run, keep a log, and fail unless the pass line is in it
run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "pass line missing from $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
